/* hw/opc_pkg.sv */
`default_nettype none

package opc_pkg;

   // ------------------------------------------------------------------------
   // Bus and memory geometry
   // ------------------------------------------------------------------------
   localparam int unsigned ADDR_W    = 11;
   localparam int unsigned DATA_W    = 8;
   localparam int unsigned LINK_W    = ADDR_W - DATA_W;   // Upper address bits in link
   localparam int unsigned MEM_BYTES = 1 << ADDR_W;       // 2 KB

   localparam logic [ADDR_W-1:0] RESET_PC  = 11'h100;     // Page zero kept for data
   localparam logic [ADDR_W-1:0] PORT_BASE = 11'h7F0;     // Window runs to top of memory

   // ------------------------------------------------------------------------
   // Output port FIFO
   // ------------------------------------------------------------------------
   localparam int unsigned FIFO_DEPTH = 8;                // Keep to a power of two
   localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

   // ------------------------------------------------------------------------
   // Processor sequence and instruction set
   // ------------------------------------------------------------------------
   typedef enum logic [2:0] {
      FETCH0 = 3'd0,   // Opcode and high address bits
      FETCH1 = 3'd1,   // Operand or low address byte
      RDMEM  = 3'd2,   // Memory operand or pointer
      RDMEM2 = 3'd3,   // LDAP only
      EXEC   = 3'd4
   } cpu_state_e;

   // Bit 4 clear means an operand read follows the fetch
   typedef enum logic [4:0] {
      AND_M = 5'b00000,
      LDA_M = 5'b00001,
      NOT_M = 5'b00010,
      ADD_M = 5'b00011,
      STAP  = 5'b01000,
      LDAP  = 5'b01001,
      AND_I = 5'b10000,
      LDA_I = 5'b10001,
      NOT_I = 5'b10010,
      ADD_I = 5'b10011,
      STA   = 5'b11000,
      JPC   = 5'b11001,
      JPZ   = 5'b11010,
      JP    = 5'b11011,
      JSR   = 5'b11100,
      RTS   = 5'b11101,
      LXA   = 5'b11110
   } opcode_e;

endpackage

`default_nettype wire

/* hw/opc_cpu.sv */
`default_nettype none

module opc_cpu (
   input  wire                          clk,
   input  wire                          reset_b,
   input  wire  [opc_pkg::DATA_W-1:0]   rdata,
   output logic [opc_pkg::ADDR_W-1:0]   address,
   output logic [opc_pkg::DATA_W-1:0]   wdata,
   output logic                         rnw
);

   opc_pkg::cpu_state_e         state_q;
   opc_pkg::opcode_e            ir_q;
   logic [opc_pkg::ADDR_W-1:0]  pc_q;
   logic [opc_pkg::ADDR_W-1:0]  oper_q;     // Operand and effective address
   logic [opc_pkg::DATA_W-1:0]  acc_q;
   logic [opc_pkg::LINK_W-1:0]  link_q;     // Bit 0 doubles as carry
   logic [opc_pkg::DATA_W:0]    sum;        // Carry out in top bit
   logic                        store;
   logic                        zero;

   // ------------------------------------------------------------------------
   // Bus side
   // ------------------------------------------------------------------------
   assign store = (state_q == opc_pkg::EXEC) &&
                  (ir_q == opc_pkg::STA || ir_q == opc_pkg::STAP);
   assign rnw   = ~store;
   assign wdata = acc_q;                    // Only sampled when rnw is low

   always_comb
   begin
      if (store || state_q == opc_pkg::RDMEM || state_q == opc_pkg::RDMEM2)
         address = oper_q;
      else
         address = pc_q;
   end

   assign zero = ~|acc_q;
   assign sum  = {1'b0, acc_q} + {1'b0, oper_q[opc_pkg::DATA_W-1:0]} +
                 {{opc_pkg::DATA_W{1'b0}}, link_q[0]};

   // ------------------------------------------------------------------------
   // Sequencer
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state_q <= opc_pkg::FETCH0;
      else
      begin
         case (state_q)
            opc_pkg::FETCH0 : state_q <= opc_pkg::FETCH1;
            opc_pkg::FETCH1 : state_q <= ir_q[4] ? opc_pkg::EXEC : opc_pkg::RDMEM;
            opc_pkg::RDMEM  : state_q <= (ir_q == opc_pkg::LDAP) ? opc_pkg::RDMEM2
                                                                 : opc_pkg::EXEC;
            opc_pkg::RDMEM2 : state_q <= opc_pkg::EXEC;
            default         : state_q <= opc_pkg::FETCH0;
         endcase
      end
   end

   // Opcode and operand capture
   always_ff @(posedge clk)
   begin
      oper_q[opc_pkg::DATA_W-1:0] <= rdata;   // Low byte follows every read
      if (state_q == opc_pkg::FETCH0)
      begin
         ir_q <= opc_pkg::opcode_e'(rdata[opc_pkg::DATA_W-1:opc_pkg::LINK_W]);
         oper_q[opc_pkg::ADDR_W-1:opc_pkg::DATA_W] <= rdata[opc_pkg::LINK_W-1:0];
      end
      else if (state_q == opc_pkg::RDMEM)
         oper_q[opc_pkg::ADDR_W-1:opc_pkg::DATA_W] <= '0;   // Pointers reach page zero
   end

   // ------------------------------------------------------------------------
   // Accumulator and link
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         acc_q  <= '0;
         link_q <= '0;
      end
      else if (state_q == opc_pkg::EXEC)
      begin
         case (ir_q)
            opc_pkg::JSR :
               {link_q, acc_q} <= pc_q;                  // Return address
            opc_pkg::LXA :
               {link_q, acc_q} <= {acc_q[opc_pkg::LINK_W-1:0],
                                   {(opc_pkg::DATA_W-opc_pkg::LINK_W){1'b0}}, link_q};
            opc_pkg::AND_M, opc_pkg::AND_I :
            begin
               link_q[0] <= 1'b0;                        // AND clears carry
               acc_q     <= acc_q & oper_q[opc_pkg::DATA_W-1:0];
            end
            opc_pkg::NOT_M, opc_pkg::NOT_I :
               acc_q <= ~oper_q[opc_pkg::DATA_W-1:0];
            opc_pkg::LDA_M, opc_pkg::LDA_I, opc_pkg::LDAP :
               acc_q <= oper_q[opc_pkg::DATA_W-1:0];
            opc_pkg::ADD_M, opc_pkg::ADD_I :
               {link_q[0], acc_q} <= sum;
            default : ;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Program counter
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         pc_q <= opc_pkg::RESET_PC;
      else if (state_q == opc_pkg::FETCH0 || state_q == opc_pkg::FETCH1)
         pc_q <= pc_q + 1'b1;
      else if (state_q == opc_pkg::EXEC)
      begin
         case (ir_q)
            opc_pkg::JP, opc_pkg::JSR :
               pc_q <= oper_q;
            opc_pkg::JPC :
               if (link_q[0])
                  pc_q <= oper_q;
            opc_pkg::JPZ :
               if (zero)
                  pc_q <= oper_q;
            opc_pkg::RTS :
               pc_q <= {link_q, acc_q};                  // Link holds high bits
            default : ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/opc_ram.sv */
`default_nettype none

module opc_ram (
   input  wire                          clk,
   input  wire  [opc_pkg::ADDR_W-1:0]   address,
   input  wire  [opc_pkg::DATA_W-1:0]   wdata,
   input  wire                          rnw,
   input  wire                          load_en,
   input  wire  [opc_pkg::ADDR_W-1:0]   load_addr,
   input  wire  [opc_pkg::DATA_W-1:0]   load_data,
   output logic [opc_pkg::DATA_W-1:0]   rdata
);

   // ------------------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------------------
   logic [opc_pkg::DATA_W-1:0] mem_q [0:opc_pkg::MEM_BYTES-1];

   // Read path is combinational so the processor sees data in the same cycle
   assign rdata = mem_q[address];

   // ------------------------------------------------------------------------
   // Write port
   // ------------------------------------------------------------------------
   // The loader runs while the processor sits in reset, so the two writers
   // never collide in normal use. Loader still wins if they do.
   always_ff @(posedge clk)
   begin
      if (load_en)
         mem_q[load_addr] <= load_data;   // Image load
      else if (!rnw)
         mem_q[address] <= wdata;         // STA / STAP from processor
   end

endmodule

`default_nettype wire

/* hw/opc_out_fifo.sv */
`default_nettype none

module opc_out_fifo (
   input  wire                          clk,
   input  wire                          reset_b,
   input  wire  [opc_pkg::ADDR_W-1:0]   address,
   input  wire  [opc_pkg::DATA_W-1:0]   wdata,
   input  wire                          rnw,
   input  wire                          out_pop,
   output logic [opc_pkg::DATA_W-1:0]   out_data,
   output logic                         out_avail,
   output logic                         out_overflow
);

   logic [opc_pkg::DATA_W-1:0]     slot_q [0:opc_pkg::FIFO_DEPTH-1];
   logic [opc_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
   logic [opc_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
   logic [opc_pkg::FIFO_PTR_W:0]   count_q;    // 0 to FIFO_DEPTH
   logic                           push_req;
   logic                           push;
   logic                           pop;
   logic                           full;

   // ------------------------------------------------------------------------
   // Port window decode
   // ------------------------------------------------------------------------
   // Window sits at the top of memory, so a lower bound is enough
   assign push_req = ~rnw && (address >= opc_pkg::PORT_BASE);

   assign full      = count_q[opc_pkg::FIFO_PTR_W];   // MSB only set at DEPTH
   assign push      = push_req && !full;              // Full drops the byte
   assign out_avail = |count_q;
   assign pop       = out_pop && out_avail;
   assign out_data  = slot_q[rd_ptr_q];

   always_ff @(posedge clk)
   begin
      if (push)
         slot_q[wr_ptr_q] <= wdata;
   end

   // ------------------------------------------------------------------------
   // Pointers, count and overflow flag
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         rd_ptr_q     <= '0;
         wr_ptr_q     <= '0;
         count_q      <= '0;
         out_overflow <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;       // Wraps at DEPTH
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({push, pop})
            2'b10   : count_q <= count_q + 1'b1;
            2'b01   : count_q <= count_q - 1'b1;
            default : ;                        // Both or neither, count holds
         endcase
         if (push_req && full)
            out_overflow <= 1'b1;              // Sticky until reset
      end
   end

endmodule

`default_nettype wire

/* hw/opc_system.sv */
`default_nettype none

module opc_system (
   input  wire                          clk,
   input  wire                          reset_b,
   input  wire                          load_en,
   input  wire  [opc_pkg::ADDR_W-1:0]   load_addr,
   input  wire  [opc_pkg::DATA_W-1:0]   load_data,
   input  wire                          out_pop,
   output logic [opc_pkg::DATA_W-1:0]   out_data,
   output logic                         out_avail,
   output logic                         out_overflow
);

   // ------------------------------------------------------------------------
   // Processor bus
   // ------------------------------------------------------------------------
   logic [opc_pkg::ADDR_W-1:0] address;
   logic [opc_pkg::DATA_W-1:0] wdata;
   logic [opc_pkg::DATA_W-1:0] rdata;
   logic                       rnw;     // High for read

   opc_cpu i_opc_cpu (
      .clk       (clk),
      .reset_b   (reset_b),
      .rdata     (rdata),
      .address   (address),
      .wdata     (wdata),
      .rnw       (rnw)
   );

   opc_ram i_opc_ram (
      .clk       (clk),
      .address   (address),
      .wdata     (wdata),
      .rnw       (rnw),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .rdata     (rdata)
   );

   // Snoops the same write bus as the memory
   opc_out_fifo i_opc_out_fifo (
      .clk          (clk),
      .reset_b      (reset_b),
      .address      (address),
      .wdata        (wdata),
      .rnw          (rnw),
      .out_pop      (out_pop),
      .out_data     (out_data),
      .out_avail    (out_avail),
      .out_overflow (out_overflow)
   );

endmodule

`default_nettype wire

/* dv/opc_sva.sv */
`default_nettype none

module opc_sva (
   input wire                            clk,
   input wire                            reset_b,
   input wire                            rnw,
   input wire  [opc_pkg::ADDR_W-1:0]     address,
   input wire                            out_avail,
   input wire                            out_overflow,
   input wire  [opc_pkg::FIFO_PTR_W:0]   fifo_count
);

   logic port_write;

   assign port_write = !rnw && (address >= opc_pkg::PORT_BASE);   // Any write into the window

   // ------------------------------------------------------------------------
   // Bus and FIFO properties
   // ------------------------------------------------------------------------
   rnw_in_reset : assert property (@(posedge clk) !reset_b |-> rnw)
      else $error("rnw low while reset_b is low");

   // An empty FIFO only shows data after a port write
   avail_needs_data : assert property (@(posedge clk) disable iff (!reset_b)
                                       (fifo_count == '0) && !port_write |=> !out_avail)
      else $error("out_avail high without a port write into an empty FIFO");

   // Sticky until reset
   overflow_sticky : assert property (@(posedge clk) disable iff (!reset_b)
                                      !$fell(out_overflow))
      else $error("out_overflow cleared outside reset");

endmodule

bind opc_system opc_sva i_opc_sva (
   .clk          (clk),
   .reset_b      (reset_b),
   .rnw          (rnw),
   .address      (address),
   .out_avail    (out_avail),
   .out_overflow (out_overflow),
   .fifo_count   (i_opc_out_fifo.count_q)
);

`default_nettype wire

/* dv/tb_opc_system.sv */
`default_nettype none

module tb_opc_system;

   localparam int    CLK_PERIOD      = 10;
   localparam int    RESET_CYCLES    = 4;
   localparam int    CYCLES_PER_PROG = 2000;
   localparam int    QUIET_CYCLES    = 50;
   localparam string TEST_FILE       = "dv/opc_tests.txt";

   localparam int KIND_LOAD   = 0;    // Memory image byte
   localparam int KIND_EXPECT = 1;    // Expected port byte
   localparam int KIND_RUN    = 2;    // End of program, overflow flag in data

   logic                        clk;
   logic                        reset_b;
   logic                        load_en;
   logic [opc_pkg::ADDR_W-1:0]  load_addr;
   logic [opc_pkg::DATA_W-1:0]  load_data;
   logic                        out_pop;
   logic [opc_pkg::DATA_W-1:0]  out_data;
   logic                        out_avail;
   logic                        out_overflow;

   int                          rec_kind [$];
   logic [opc_pkg::ADDR_W-1:0]  rec_addr [$];
   logic [opc_pkg::DATA_W-1:0]  rec_data [$];
   logic [opc_pkg::ADDR_W-1:0]  image_addr [$];   // Program being run
   logic [opc_pkg::DATA_W-1:0]  image_data [$];
   logic [opc_pkg::DATA_W-1:0]  expect_q [$];
   int                          prog_count;
   integer                      seed;

   opc_system i_opc_system (
      .clk          (clk),
      .reset_b      (reset_b),
      .load_en      (load_en),
      .load_addr    (load_addr),
      .load_data    (load_data),
      .out_pop      (out_pop),
      .out_data     (out_data),
      .out_avail    (out_avail),
      .out_overflow (out_overflow)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   task automatic fail_now(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_byte(input string name, input logic [opc_pkg::DATA_W-1:0] expected,
                             input logic [opc_pkg::DATA_W-1:0] actual);
      if (actual !== expected)
         fail_now($sformatf("ERROR at time %0t: %s is 0x%h, expected 0x%h",
                            $time, name, actual, expected));
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         fail_now($sformatf("ERROR at time %0t: %s is %b, expected %b",
                            $time, name, actual, expected));
   endtask

   // ------------------------------------------------------------------------
   // Test file
   // ------------------------------------------------------------------------
   task automatic read_tests();
      int                         fd;
      int                         n;
      int                         cnt;
      int                         i;
      int                         runs;
      int unsigned                a;
      int unsigned                v;
      string                      tag;
      string                      rest;
      logic [opc_pkg::ADDR_W-1:0] addr;
      runs = 0;
      fd   = $fopen(TEST_FILE, "r");
      if (fd == 0)
         fail_now($sformatf("Cannot open test file %s", TEST_FILE));
      n = $fscanf(fd, " %s", tag);
      while (n == 1)
      begin
         if (tag == "#")
            n = $fgets(rest, fd);                // Skip comment text
         else if (tag == "m")
         begin
            n    = $fscanf(fd, " %h %d", a, cnt);
            addr = a[opc_pkg::ADDR_W-1:0];
            for (i = 0; i < cnt; i++)
            begin
               n = $fscanf(fd, " %h", v);
               rec_kind.push_back(KIND_LOAD);
               rec_addr.push_back(addr);
               rec_data.push_back(v[opc_pkg::DATA_W-1:0]);
               addr = addr + 1'b1;
            end
         end
         else if (tag == "e")
         begin
            n = $fscanf(fd, " %d", cnt);
            for (i = 0; i < cnt; i++)
            begin
               n = $fscanf(fd, " %h", v);
               rec_kind.push_back(KIND_EXPECT);
               rec_addr.push_back('0);
               rec_data.push_back(v[opc_pkg::DATA_W-1:0]);
            end
         end
         else if (tag == "r")
         begin
            n = $fscanf(fd, " %d", v);
            rec_kind.push_back(KIND_RUN);
            rec_addr.push_back('0);
            rec_data.push_back(v[opc_pkg::DATA_W-1:0]);
            runs++;
         end
         else
            fail_now($sformatf("Unknown record %s in test file", tag));
         n = $fscanf(fd, " %s", tag);
      end
      $fclose(fd);
      prog_count = runs;
   endtask

   // ------------------------------------------------------------------------
   // Program run
   // ------------------------------------------------------------------------
   task automatic apply_reset();
      @(negedge clk);
      reset_b = 1'b0;
      out_pop = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      check_flag("out_avail", 1'b0, out_avail);        // Reset empties the FIFO
      check_flag("out_overflow", 1'b0, out_overflow);
   endtask

   task automatic run_program(input int prog, input logic overflow_exp);
      int i;
      int got;
      int waited;
      apply_reset();
      for (i = 0; i < image_addr.size(); i++)
      begin
         load_en   = 1'b1;
         load_addr = image_addr[i];
         load_data = image_data[i];
         @(negedge clk);
      end
      load_en = 1'b0;
      reset_b = 1'b1;
      // Port stays unread until the FIFO has filled and dropped a byte
      if (overflow_exp)
      begin
         waited = 0;
         while (!out_overflow)
         begin
            if (waited == CYCLES_PER_PROG)
               fail_now($sformatf("Program %0d never set out_overflow", prog));
            waited++;
            @(negedge clk);
         end
      end
      got = 0;
      while (got < expect_q.size())
      begin
         out_pop = 1'b0;
         if (out_avail && (($random(seed) & 1) != 0))   // Random pops vary occupancy
         begin
            check_byte("out_data", expect_q[got], out_data);
            got++;
            out_pop = 1'b1;
         end
         @(negedge clk);
      end
      out_pop = 1'b0;
      repeat (QUIET_CYCLES)
      begin
         if (out_avail)
            fail_now($sformatf("Program %0d sent a byte after its last expected one", prog));
         @(negedge clk);
      end
      check_flag("out_overflow", overflow_exp, out_overflow);
   endtask

   task automatic run_all_programs();
      int r;
      int prog;
      prog = 0;
      for (r = 0; r < rec_kind.size(); r++)
      begin
         case (rec_kind[r])
            KIND_LOAD :
            begin
               image_addr.push_back(rec_addr[r]);
               image_data.push_back(rec_data[r]);
            end
            KIND_EXPECT :
               expect_q.push_back(rec_data[r]);
            default :
            begin
               run_program(prog, rec_data[r][0]);
               prog++;
               image_addr.delete();
               image_data.delete();
               expect_q.delete();
            end
         endcase
      end
      apply_reset();                                   // Flags left by the last program
   endtask

   initial
   begin
      seed      = 54;
      reset_b   = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      out_pop   = 1'b0;
      read_tests();
      if (prog_count == 0)
         fail_now("Test file holds no programs");
      run_all_programs();
      $display("TEST OK");
      $finish;
   end

   // Watchdog scaled by the number of programs
   initial
   begin
      wait (prog_count > 0);
      #(prog_count * CYCLES_PER_PROG * CLK_PERIOD);
      fail_now($sformatf("Watchdog expired at time %0t before all programs finished", $time));
   end

endmodule

`default_nettype wire

/* build.f */
hw/opc_pkg.sv
hw/opc_cpu.sv
hw/opc_ram.sv
hw/opc_out_fifo.sv
hw/opc_system.sv
dv/opc_sva.sv
dv/tb_opc_system.sv

/* Makefile */
# Verilator build and run for the accumulator processor testbench

VERILATOR ?= verilator
TOP       ?= tb_opc_system
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, the file list or this Makefile changes
$(SIM): $(SOURCES) $(FILELIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulator prints the pass line
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

/* dv/opc_tests.txt */
# m ADDR COUNT BYTES.. loads memory, e COUNT BYTES.. lists the port output in order
# r OVF runs the program, OVF 1 when out_overflow must end high (COUNT, OVF decimal)
# ALU immediate and memory forms with a carry chain
m 100 16 88 3C 80 0F C7 F0 10 10 C7 F1 98 6B C7 F0 18 11
m 110 16 C7 F0 08 12 00 13 C7 F0 90 81 98 C4 98 00 C7 F0
m 120 2 D9 20
m 010 4 5A 20 F0 3C
e 6 0C A5 10 31 30 43
r 0
# LDAP and STAP through page zero pointers
m 100 16 88 77 40 14 88 00 08 20 C7 F0 48 15 C7 F1 4A 00
m 110 16 C7 F2 88 3D 42 01 08 21 C7 F0 0A 21 C7 F0 D9 1E
m 014 4 20 16 D2 5C
m 200 2 17 21
m 221 1 EE
e 5 77 D2 5C 3D EE
r 0
# JPC, JPZ and JP shown by marker bytes
m 100 16 88 00 C9 08 88 11 C7 F0 88 00 D1 10 88 22 C7 F0
m 110 16 88 FF 98 01 C9 1A 88 33 C7 F0 88 44 C7 F0 D1 24
m 120 16 88 55 C7 F0 80 00 C9 2C 88 66 C7 F0 D9 32 88 77
m 130 8 C7 F0 88 88 C7 F0 D9 36
e 5 11 44 55 66 88
r 0
# JSR, LXA and RTS back to the caller
m 100 2 D9 F6
m 1F6 8 E1 40 88 99 C7 F0 D9 FC
m 140 14 C7 F0 C0 10 F0 00 C7 F1 F0 00 08 10 E8 00
e 3 F8 01 99
r 0
# Nine port writes into an eight entry FIFO
m 100 16 88 A0 C7 F0 98 01 C7 F0 98 01 C7 F0 98 01 C7 F0
m 110 16 98 01 C7 F0 98 01 C7 F0 98 01 C7 F0 98 01 C7 F0
m 120 6 98 01 C7 F0 D9 24
e 8 A0 A1 A2 A3 A4 A5 A6 A7
r 1
